// ==== project.f ====
+incdir+logic
logic/l2_addr_pkg.sv
logic/l2_data_pkg.sv
logic/l2_mem_if.sv
logic/l2_wr_decode.sv
logic/l2_dir_array.sv
logic/l2_line_array.sv
logic/l2_localmem.sv
sim/l2_localmem_checker.sv
sim/tb_l2_localmem.sv

// ==== Bender.yml ====
package:
  name: l2_localmem

sources:
  - include_dirs:
      - logic
    files:
      - logic/l2_addr_pkg.sv
      - logic/l2_data_pkg.sv
      - logic/l2_mem_if.sv
      - logic/l2_wr_decode.sv
      - logic/l2_dir_array.sv
      - logic/l2_line_array.sv
      - logic/l2_localmem.sv
  - target: simulation
    include_dirs:
      - logic
    files:
      - sim/l2_localmem_checker.sv
      - sim/tb_l2_localmem.sv

// ==== sim/tb_l2_localmem.sv ====
/* testbench for the L2 local memory that applies a table of strobe rows on falling
   edges, one row per cycle, while the checker compares every read */
`timescale 1ns/1ps
`include "l2_mem_macros.svh"

module tb_l2_localmem;
    import l2_addr_pkg::*;
    import l2_data_pkg::*;

    localparam int CLK_PERIOD = 100;
    localparam int RST_CYCLES = 4;
    localparam int MAX_ROWS = 64;
    localparam logic [31:0] SEED = 32'hd816_74c5;

    localparam logic [6:0] OP_RD = 7'b000_0001;
    localparam logic [6:0] OP_LINE = 7'b000_0010;
    localparam logic [6:0] OP_STATE = 7'b000_0100;
    localparam logic [6:0] OP_PUT = 7'b000_1000;
    localparam logic [6:0] OP_EVICT = 7'b001_0000;
    localparam logic [6:0] OP_INIT = 7'b010_0000;
    localparam logic [6:0] OP_RST = 7'b100_0000;

    typedef struct packed {
        logic [127:0] name;
        logic [6:0] ops;
        l2_set_t set_in;
        l2_way_t way;
        line_t line;
        l2_tag_t tag;
        hprot_t hprot;
        state_t state;
        l2_way_t evict_way;
    } row_t;

    row_t rows [MAX_ROWS];
    int num_rows;
    logic table_ready;
    int error_count;
    int check_count;
    logic [127:0] test_name;

    logic clk;
    logic wr_rst;
    logic rd_en;
    l2_set_t set_in;
    l2_way_t way;
    logic wr_en_line;
    logic wr_en_state;
    logic wr_en_put_reqs;
    logic wr_en_evict_way;
    logic init_set;
    line_t wr_data_line;
    l2_tag_t wr_data_tag;
    hprot_t wr_data_hprot;
    state_t wr_data_state;
    l2_way_t wr_data_evict_way;
    line_t rd_data_line [`L2_WAYS];
    l2_tag_t rd_data_tag [`L2_WAYS];
    hprot_t rd_data_hprot [`L2_WAYS];
    state_t rd_data_state [`L2_WAYS];
    l2_way_t rd_data_evict_way;

    always #(CLK_PERIOD / 2) clk = ~clk;

    l2_localmem dut0 (.*);

    l2_localmem_checker chk0 (.*);

    // line, tag and state data are random
    task automatic add_row(input logic [127:0] name, input logic [6:0] ops,
                           input int set_idx, input int way_idx,
                           input int hprot, input int evict);
        row_t r;
        r.name = name;
        r.ops = ops;
        r.set_in = l2_set_t'(set_idx);
        r.way = l2_way_t'(way_idx);
        r.line = {$urandom, $urandom, $urandom, $urandom};
        r.tag = l2_tag_t'($urandom);
        r.hprot = hprot_t'(hprot);
        r.state = state_t'($urandom);
        r.evict_way = l2_way_t'(evict);
        rows[num_rows] = r;
        num_rows++;
    endtask

    task automatic build_table();
        logic [6:0] ops;
        int pick;
        add_row("idle_after_rst", 0, 0, 0, 0, 0);
        for (int w = 0; w < `L2_WAYS; w++) begin
            add_row("put_fill_s5", OP_PUT, 5, w, w % 2, 0);
        end
        add_row("put_rd_s5", OP_RD, 5, 0, 0, 0);
        add_row("put_one_way", OP_PUT, 5, 2, 1, 0);
        add_row("put_keep_others", OP_RD, 5, 0, 0, 0);
        add_row("line_only_w1", OP_LINE, 5, 1, 0, 0);
        add_row("line_only_rd", OP_RD, 5, 0, 0, 0);
        add_row("state_only_w3", OP_STATE, 5, 3, 0, 0);
        add_row("state_only_rd", OP_RD, 5, 0, 0, 0);
        for (int w = 0; w < `L2_WAYS; w++) begin
            add_row("put_fill_s9", OP_PUT, 9, w, 1, 0);
        end
        add_row("init_s9", OP_INIT, 9, 0, 0, 0);
        add_row("init_rd_s9", OP_RD, 9, 0, 0, 0);
        add_row("init_rd_s5", OP_RD, 5, 0, 0, 0);
        // the way field must not matter for the pointer
        add_row("evict_s5", OP_EVICT, 5, 3, 0, 2);
        add_row("evict_s9", OP_EVICT, 9, 1, 0, 1);
        add_row("evict_rd_s5", OP_RD, 5, 0, 0, 0);
        add_row("evict_rd_s9", OP_RD, 9, 0, 0, 0);
        add_row("rw_put_old", OP_RD | OP_PUT, 5, 0, 1, 0);
        add_row("rw_put_new", OP_RD, 5, 0, 0, 0);
        add_row("rw_line_old", OP_RD | OP_LINE, 9, 2, 0, 0);
        add_row("rw_line_new", OP_RD, 9, 0, 0, 0);
        add_row("rw_evict_old", OP_RD | OP_EVICT, 9, 0, 0, 3);
        add_row("rw_evict_new", OP_RD, 9, 0, 0, 0);
        add_row("hold_idle", 0, 9, 0, 0, 0);
        add_row("hold_write", OP_LINE, 9, 1, 0, 0);
        add_row("hold_set_change", 0, 5, 0, 0, 0);
        add_row("mid_reset", OP_RST, 5, 0, 0, 0);
        add_row("mid_reset", OP_RST, 5, 0, 0, 0);
        add_row("after_reset", 0, 5, 0, 0, 0);
        add_row("kept_rd_s5", OP_RD, 5, 0, 0, 0);
        add_row("kept_rd_s9", OP_RD, 9, 0, 0, 0);
        for (int i = 0; i < 10; i++) begin
            ops = 7'($urandom) & (OP_RD | OP_LINE | OP_STATE | OP_PUT | OP_EVICT);
            pick = $urandom % 3;
            add_row("random_mix", ops, (pick == 0) ? 5 : (pick == 1) ? 9 : 20,
                    $urandom % `L2_WAYS, $urandom % 2, $urandom % `L2_WAYS);
        end
        add_row("final_rd_s5", OP_RD, 5, 0, 0, 0);
        add_row("final_rd_s9", OP_RD, 9, 0, 0, 0);
        add_row("final_idle", 0, 0, 0, 0, 0);
    endtask

    task automatic apply_row(input row_t r);
        test_name = r.name;
        wr_rst = (r.ops & OP_RST) != 0;
        rd_en = (r.ops & OP_RD) != 0;
        wr_en_line = (r.ops & OP_LINE) != 0;
        wr_en_state = (r.ops & OP_STATE) != 0;
        wr_en_put_reqs = (r.ops & OP_PUT) != 0;
        wr_en_evict_way = (r.ops & OP_EVICT) != 0;
        init_set = (r.ops & OP_INIT) != 0;
        set_in = r.set_in;
        way = r.way;
        wr_data_line = r.line;
        wr_data_tag = r.tag;
        wr_data_hprot = r.hprot;
        wr_data_state = r.state;
        wr_data_evict_way = r.evict_way;
    endtask

    initial begin
        void'($urandom(SEED));
        clk = 1'b0;
        num_rows = 0;
        table_ready = 1'b0;
        build_table();
        table_ready = 1'b1;
        apply_row('0);
        wr_rst = 1'b1;
        test_name = "reset";
        repeat (RST_CYCLES) @(posedge clk);
        for (int i = 0; i < num_rows; i++) begin
            @(negedge clk);
            apply_row(rows[i]);
        end
        // let the last read reach the checker
        repeat (2) @(negedge clk);
        @(posedge clk);
        $display("compares %0d, mismatches %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

    // watchdog sized from the table length
    initial begin
        wait (table_ready);
        #((num_rows + RST_CYCLES + 20) * CLK_PERIOD);
        $display("timeout: the stimulus table did not finish in %0d cycles",
                 num_rows + RST_CYCLES + 20);
        $display("RESULT: FAIL");
        $finish;
    end

endmodule

// ==== sim/l2_localmem_checker.sv ====
/* testbench checker that keeps its own copy of every store of the L2 local memory
   and compares the registered read outputs of the DUT on each falling edge */
`timescale 1ns/1ps
`include "l2_mem_macros.svh"

module l2_localmem_checker (
    input logic clk,
    input logic wr_rst,
    input logic rd_en,
    input l2_addr_pkg::l2_set_t set_in,
    input l2_addr_pkg::l2_way_t way,
    input logic wr_en_line,
    input logic wr_en_state,
    input logic wr_en_put_reqs,
    input logic wr_en_evict_way,
    input logic init_set,
    input l2_data_pkg::line_t wr_data_line,
    input l2_addr_pkg::l2_tag_t wr_data_tag,
    input l2_data_pkg::hprot_t wr_data_hprot,
    input l2_data_pkg::state_t wr_data_state,
    input l2_addr_pkg::l2_way_t wr_data_evict_way,
    input l2_data_pkg::line_t rd_data_line [`L2_WAYS],
    input l2_addr_pkg::l2_tag_t rd_data_tag [`L2_WAYS],
    input l2_data_pkg::hprot_t rd_data_hprot [`L2_WAYS],
    input l2_data_pkg::state_t rd_data_state [`L2_WAYS],
    input l2_addr_pkg::l2_way_t rd_data_evict_way,
    input logic [127:0] test_name,
    output int error_count,
    output int check_count
);
    import l2_addr_pkg::*;
    import l2_data_pkg::*;

    // unwritten model entries stay X like the RAMs
    line_t line_m [`L2_WAYS][`L2_SETS];
    l2_tag_t tag_m [`L2_WAYS][`L2_SETS];
    hprot_t hprot_m [`L2_WAYS][`L2_SETS];
    state_t state_m [`L2_WAYS][`L2_SETS];
    l2_way_t evict_m [`L2_SETS];

    line_t exp_line [`L2_WAYS];
    l2_tag_t exp_tag [`L2_WAYS];
    hprot_t exp_hprot [`L2_WAYS];
    state_t exp_state [`L2_WAYS];
    l2_way_t exp_evict;
    logic [127:0] exp_name;
    logic started;
    logic sel;

    initial begin
        error_count = 0;
        check_count = 0;
        started = 1'b0;
    end

    task automatic compare_value(input string field, input int w,
                                 input logic [127:0] exp_v, input logic [127:0] act_v);
        check_count++;
        if (act_v !== exp_v) begin
            error_count++;
            $display("ERROR %0s: %0s way %0d expected %0h actual %0h",
                     exp_name, field, w, exp_v, act_v);
        end
    endtask

    // read the set before applying this edge's writes
    always @(posedge clk) begin
        started = 1'b1;
        // the row sampled here owns the compare on the next falling edge
        exp_name = test_name;
        if (wr_rst) begin
            for (int w = 0; w < `L2_WAYS; w++) begin
                exp_line[w] = '0;
                exp_tag[w] = '0;
                exp_hprot[w] = '0;
                exp_state[w] = '0;
            end
            exp_evict = '0;
        end else if (rd_en) begin
            for (int w = 0; w < `L2_WAYS; w++) begin
                exp_line[w] = line_m[w][set_in];
                exp_tag[w] = tag_m[w][set_in];
                exp_hprot[w] = hprot_m[w][set_in];
                exp_state[w] = state_m[w][set_in];
            end
            exp_evict = evict_m[set_in];
        end
        for (int w = 0; w < `L2_WAYS; w++) begin
            sel = init_set || (way == w);
            if (sel && (wr_en_line || wr_en_put_reqs)) begin
                line_m[w][set_in] = wr_data_line;
            end
            if (sel && wr_en_put_reqs) begin
                tag_m[w][set_in] = wr_data_tag;
                hprot_m[w][set_in] = wr_data_hprot;
            end
            if (sel && (wr_en_state || init_set || wr_en_put_reqs)) begin
                state_m[w][set_in] = wr_data_state;
            end
        end
        if (wr_en_evict_way) begin
            evict_m[set_in] = wr_data_evict_way;
        end
    end

    always @(negedge clk) begin
        if (started) begin
            for (int w = 0; w < `L2_WAYS; w++) begin
                compare_value("line", w, exp_line[w], rd_data_line[w]);
                compare_value("tag", w, exp_tag[w], rd_data_tag[w]);
                compare_value("hprot", w, exp_hprot[w], rd_data_hprot[w]);
                compare_value("state", w, exp_state[w], rd_data_state[w]);
            end
            compare_value("evict_way", 0, exp_evict, rd_data_evict_way);
        end
    end

endmodule

// ==== logic/l2_localmem.sv ====
/* L2 cache local memory top level with plain ports; strobes act on the rising
   edge where they are high and reads return all ways of a set one cycle later */
`timescale 1ns/1ps
`include "l2_mem_macros.svh"

module l2_localmem (
    input logic clk,
    input logic wr_rst,
    input logic rd_en,
    input l2_addr_pkg::l2_set_t set_in,
    input l2_addr_pkg::l2_way_t way,
    input logic wr_en_line,
    input logic wr_en_state,
    input logic wr_en_put_reqs,
    input logic wr_en_evict_way,
    input logic init_set,
    input l2_data_pkg::line_t wr_data_line,
    input l2_addr_pkg::l2_tag_t wr_data_tag,
    input l2_data_pkg::hprot_t wr_data_hprot,
    input l2_data_pkg::state_t wr_data_state,
    input l2_addr_pkg::l2_way_t wr_data_evict_way,
    output l2_data_pkg::line_t rd_data_line [`L2_WAYS],
    output l2_addr_pkg::l2_tag_t rd_data_tag [`L2_WAYS],
    output l2_data_pkg::hprot_t rd_data_hprot [`L2_WAYS],
    output l2_data_pkg::state_t rd_data_state [`L2_WAYS],
    output l2_addr_pkg::l2_way_t rd_data_evict_way
);
    import l2_addr_pkg::*;
    import l2_data_pkg::*;

    l2_tag_t dir_tag [`L2_WAYS];
    state_t dir_state [`L2_WAYS];
    hprot_t dir_hprot [`L2_WAYS];
    l2_way_t dir_evict_way;
    line_t line_rd [`L2_WAYS];

    l2_mem_bus_if mem_bus ();

    assign mem_bus.set_in = set_in;
    assign mem_bus.rd_en = rd_en;
    assign mem_bus.wr_data_line = wr_data_line;
    assign mem_bus.wr_data_tag = wr_data_tag;
    assign mem_bus.wr_data_hprot = wr_data_hprot;
    assign mem_bus.wr_data_state = wr_data_state;
    assign mem_bus.wr_data_evict_way = wr_data_evict_way;

    l2_wr_decode wr_decode0 (
        .way(way),
        .wr_en_line(wr_en_line),
        .wr_en_state(wr_en_state),
        .wr_en_put_reqs(wr_en_put_reqs),
        .wr_en_evict_way(wr_en_evict_way),
        .init_set(init_set),
        .bus(mem_bus)
    );

    l2_dir_array dir_array0 (
        .clk(clk),
        .wr_rst(wr_rst),
        .bus(mem_bus),
        .rd_tag(dir_tag),
        .rd_state(dir_state),
        .rd_hprot(dir_hprot),
        .rd_evict_way(dir_evict_way)
    );

    l2_line_array line_array0 (
        .clk(clk),
        .wr_rst(wr_rst),
        .bus(mem_bus),
        .rd_line(line_rd)
    );

    // gather each way's directory entry and line onto the outputs
    always_comb begin
        for (int w = 0; w < `L2_WAYS; w++) begin
            rd_data_line[w] = line_rd[w];
            rd_data_tag[w] = dir_tag[w];
            rd_data_hprot[w] = dir_hprot[w];
            rd_data_state[w] = dir_state[w];
        end
        rd_data_evict_way = dir_evict_way;
    end

endmodule

// ==== logic/l2_line_array.sv ====
/* data side of the L2 local memory: one line RAM per way, all ways of the
   addressed set are read together with one cycle latency */
`timescale 1ns/1ps
`include "l2_mem_macros.svh"

module l2_line_array (
    input logic clk,
    input logic wr_rst,
    l2_mem_bus_if.line bus,
    output l2_data_pkg::line_t rd_line [`L2_WAYS]
);
    import l2_addr_pkg::*;
    import l2_data_pkg::*;

    line_t line_mem [`L2_WAYS][`L2_SETS];
    l2_set_t rd_set;

    assign rd_set = bus.set_in;

    // written by line writes and put requests
    always_ff @(posedge clk) begin
        for (int w = 0; w < `L2_WAYS; w++) begin
            if (bus.line_wr_mask[w]) begin
                line_mem[w][bus.set_in] <= bus.wr_data_line;
            end
        end
    end

    // read first, outputs hold while rd_en is low
    always_ff @(posedge clk) begin
        if (wr_rst) begin
            for (int w = 0; w < `L2_WAYS; w++) begin
                rd_line[w] <= '0;
            end
        end else if (bus.rd_en) begin
            for (int w = 0; w < `L2_WAYS; w++) begin
                rd_line[w] <= line_mem[w][rd_set];
            end
        end
    end

endmodule

// ==== logic/l2_dir_array.sv ====
/* directory side of the L2 local memory: tag, state and hprot per way plus
   the per-set eviction pointer, read one set at a time with one cycle latency */
`timescale 1ns/1ps
`include "l2_mem_macros.svh"

module l2_dir_array (
    input logic clk,
    input logic wr_rst,
    l2_mem_bus_if.dir bus,
    output l2_addr_pkg::l2_tag_t rd_tag [`L2_WAYS],
    output l2_data_pkg::state_t rd_state [`L2_WAYS],
    output l2_data_pkg::hprot_t rd_hprot [`L2_WAYS],
    output l2_addr_pkg::l2_way_t rd_evict_way
);
    import l2_addr_pkg::*;
    import l2_data_pkg::*;

    l2_tag_t tag_mem [`L2_WAYS][`L2_SETS];
    state_t state_mem [`L2_WAYS][`L2_SETS];
    hprot_t hprot_mem [`L2_WAYS][`L2_SETS];
    l2_way_t evict_mem [`L2_SETS];

    // tag and hprot only change on a put request
    always_ff @(posedge clk) begin
        for (int w = 0; w < `L2_WAYS; w++) begin
            if (bus.tag_wr_mask[w]) begin
                tag_mem[w][bus.set_in] <= bus.wr_data_tag;
                hprot_mem[w][bus.set_in] <= bus.wr_data_hprot;
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int w = 0; w < `L2_WAYS; w++) begin
            if (bus.state_wr_mask[w]) begin
                state_mem[w][bus.set_in] <= bus.wr_data_state;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (bus.evict_we) begin
            evict_mem[bus.set_in] <= bus.wr_data_evict_way;
        end
    end

    // read first: same-edge writes show up on the next read
    always_ff @(posedge clk) begin
        if (wr_rst) begin
            for (int w = 0; w < `L2_WAYS; w++) begin
                rd_tag[w] <= '0;
                rd_state[w] <= '0;
                rd_hprot[w] <= '0;
            end
            rd_evict_way <= '0;
        end else if (bus.rd_en) begin
            for (int w = 0; w < `L2_WAYS; w++) begin
                rd_tag[w] <= tag_mem[w][bus.set_in];
                rd_state[w] <= state_mem[w][bus.set_in];
                rd_hprot[w] <= hprot_mem[w][bus.set_in];
            end
            rd_evict_way <= evict_mem[bus.set_in];
        end
    end

endmodule

// ==== logic/l2_wr_decode.sv ====
/* write enable decoder: turns way, init_set and the field strobes into
   per-way write masks for the directory and line arrays */
`timescale 1ns/1ps

module l2_wr_decode (
    input l2_addr_pkg::l2_way_t way,
    input logic wr_en_line,
    input logic wr_en_state,
    input logic wr_en_put_reqs,
    input logic wr_en_evict_way,
    input logic init_set,
    l2_mem_bus_if.decode bus
);
    import l2_addr_pkg::*;

    l2_way_mask_t way_sel;
    logic line_we;
    logic tag_we;
    logic state_we;

    // set init hits every way, otherwise only the addressed one
    always_comb begin
        way_sel = '0;
        if (init_set) begin
            way_sel = '1;
        end else begin
            way_sel[way] = 1'b1;
        end
    end

    // field enables
    always_comb begin
        line_we = wr_en_line | wr_en_put_reqs;
        tag_we = wr_en_put_reqs;
        state_we = wr_en_state | init_set | wr_en_put_reqs;
    end

    always_comb begin
        bus.line_wr_mask = way_sel & {$bits(l2_way_mask_t){line_we}};
        bus.tag_wr_mask = way_sel & {$bits(l2_way_mask_t){tag_we}};
        bus.state_wr_mask = way_sel & {$bits(l2_way_mask_t){state_we}};
    end

    // one pointer per set, way does not matter
    assign bus.evict_we = wr_en_evict_way;

endmodule

// ==== logic/l2_mem_if.sv ====
/* internal bus between the write decoder and the directory and line arrays
   the top level drives set, read enable and write data; the decoder drives the masks */
`timescale 1ns/1ps
`include "l2_mem_macros.svh"

interface l2_mem_bus_if;
    import l2_addr_pkg::*;
    import l2_data_pkg::*;

    // address and read strobe, shared by all ways
    l2_set_t set_in;
    logic rd_en;

    // write data
    line_t wr_data_line;
    l2_tag_t wr_data_tag;
    hprot_t wr_data_hprot;
    state_t wr_data_state;
    l2_way_t wr_data_evict_way;

    // per-way write masks from the decoder
    l2_way_mask_t line_wr_mask;
    l2_way_mask_t tag_wr_mask;
    l2_way_mask_t state_wr_mask;
    logic evict_we;

    modport decode (
        output line_wr_mask,
        output tag_wr_mask,
        output state_wr_mask,
        output evict_we
    );

    // tag mask also covers hprot
    modport dir (
        input set_in,
        input rd_en,
        input tag_wr_mask,
        input state_wr_mask,
        input evict_we,
        input wr_data_tag,
        input wr_data_hprot,
        input wr_data_state,
        input wr_data_evict_way
    );

    modport line (
        input set_in,
        input rd_en,
        input line_wr_mask,
        input wr_data_line
    );

endinterface

// ==== logic/l2_data_pkg.sv ====
/* payload types held by the L2 local memory: line, hprot and state */
`include "l2_mem_macros.svh"

package l2_data_pkg;

    // full cache line
    typedef logic [`L2_LINE_BITS-1:0] line_t;

    // protection bit stored with each line
    typedef logic [`L2_HPROT_BITS-1:0] hprot_t;

    // coherence state, never decoded here
    typedef logic [`L2_STATE_BITS-1:0] state_t;

endpackage

// ==== logic/l2_addr_pkg.sv ====
/* indexing types for the L2 local memory: set, way, way mask and tag */
`include "l2_mem_macros.svh"

package l2_addr_pkg;

    // selects one set in every way
    typedef logic [`L2_SET_BITS-1:0] l2_set_t;

    // way index, also used as the eviction pointer
    typedef logic [`L2_WAY_BITS-1:0] l2_way_t;

    // one write enable bit per way
    typedef logic [`L2_WAYS-1:0] l2_way_mask_t;

    typedef logic [`L2_TAG_BITS-1:0] l2_tag_t;

endpackage

// ==== logic/l2_mem_macros.svh ====
/* size definitions for the L2 local memory
   include in any file that needs set, way or field widths */
`ifndef L2_MEM_MACROS_SVH
`define L2_MEM_MACROS_SVH

// set index width and number of sets
`define L2_SET_BITS 6
`define L2_SETS (1 << `L2_SET_BITS)

// associativity
`define L2_WAYS 4
`define L2_WAY_BITS 2

// tag field
`define L2_TAG_BITS 14

// one cache line
`define L2_LINE_BITS 128

// coherence state code, opaque to the memory
`define L2_STATE_BITS 3

// protection bit
`define L2_HPROT_BITS 1

`endif
